//--- verilog/mdu_pkg.sv
////////////////////
// mdu shared definitions
// opcodes, data widths and the divide-by-zero rule
////////////////////
`default_nettype none

package mdu_pkg;

    localparam int DATA_W  = 32;
    localparam int DWORD_W = 64;
    localparam int HALF_W  = DATA_W / 2;

    // multiply/divide and special-register opcodes
    typedef enum logic [3:0] {
        OP_NOP   = 4'h0,
        OP_MFHI  = 4'h1,
        OP_MFLO  = 4'h2,
        OP_MTHI  = 4'h3,
        OP_MTLO  = 4'h4,
        OP_MUL   = 4'h5,
        OP_MULT  = 4'h6,
        OP_MULTU = 4'h7,
        OP_MADD  = 4'h8,
        OP_MADDU = 4'h9,
        OP_MSUB  = 4'ha,
        OP_MSUBU = 4'hb,
        OP_DIV   = 4'hc,
        OP_DIVU  = 4'hd,
        OP_MFC0  = 4'he,
        OP_MTC0  = 4'hf
    } mdu_op_e;

    // a zero divisor gives an all-ones quotient and the dividend as remainder
    localparam logic [DATA_W-1:0] DIV_ZERO_QUOT = '1;

    // operations that treat rs and rt as two's complement
    function automatic logic op_is_signed(mdu_op_e op);
        return (op == OP_MUL) || (op == OP_MULT) || (op == OP_MADD) ||
               (op == OP_MSUB) || (op == OP_DIV);
    endfunction

    function automatic logic op_is_div(mdu_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU);
    endfunction

endpackage

`default_nettype wire

//--- verilog/mdu_ex_stage.sv
////////////////////
// mdu execute stage
// command latch, operand magnitudes, partial products, divider start
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mdu_ex_stage #(
    parameter int CP0_REGS = 8
) (
    input  wire                             clk_i,
    input  wire                             rst_n_i,
    input  wire                             cmd_req_i,
    output logic                            cmd_ack_o,
    input  wire mdu_pkg::mdu_op_e           cmd_op_i,
    input  wire [mdu_pkg::DATA_W-1:0]       cmd_rs_i,
    input  wire [mdu_pkg::DATA_W-1:0]       cmd_rt_i,
    input  wire [$clog2(CP0_REGS):0]        cmd_sel_i,
    output logic                            div_req_o,
    output logic                            div_signed_o,
    output logic [mdu_pkg::DATA_W-1:0]      div_a_o,
    output logic [mdu_pkg::DATA_W-1:0]      div_b_o,
    input  wire                             div_ack_i,
    input  wire [mdu_pkg::DATA_W-1:0]       div_quot_i,
    input  wire [mdu_pkg::DATA_W-1:0]       div_rem_i,
    output mdu_pkg::mdu_op_e                op_o,
    output logic [mdu_pkg::DATA_W-1:0]      res_src_o,
    output logic [$clog2(CP0_REGS):0]       sel_o,
    output logic [mdu_pkg::DWORD_W-1:0]     mul_lo_o,
    output logic [mdu_pkg::DWORD_W-1:0]     mul_hi_o,
    output logic                            mul_neg_o,
    output logic [mdu_pkg::DWORD_W-1:0]     div_res_o,
    output logic                            wb_o
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {IDLE, EXEC, DIVWAIT, ACK} state_e;

    state_e                    state_q;
    logic                      div_req_q;
    mdu_op_e                   op_q;
    logic [DATA_W-1:0]         rs_q;
    logic [DATA_W-1:0]         rt_q;
    logic [$clog2(CP0_REGS):0] sel_q;
    logic [DWORD_W-1:0]        div_res_q;
    logic                      sgn;
    logic [DATA_W-1:0]         a_abs;
    logic [DATA_W-1:0]         b_abs;
    logic [DATA_W-1:0]         pp_ll;
    logic [DATA_W-1:0]         pp_hl;
    logic [DATA_W-1:0]         pp_lh;
    logic [DATA_W-1:0]         pp_hh;

    ////////////////////
    // handshake control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            div_req_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cmd_req_i && op_is_div(cmd_op_i)) begin
                        state_q   <= DIVWAIT;
                        div_req_q <= 1'b1;
                    end else if (cmd_req_i) begin
                        state_q <= EXEC;
                    end
                end
                DIVWAIT: begin
                    if (div_ack_i) begin
                        state_q   <= EXEC;
                        div_req_q <= 1'b0;
                    end
                end
                EXEC: state_q <= ACK;
                // leave only once master and divider have both released
                ACK: begin
                    if (!cmd_req_i && !div_ack_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && cmd_req_i) begin
            op_q  <= cmd_op_i;
            rs_q  <= cmd_rs_i;
            rt_q  <= cmd_rt_i;
            sel_q <= cmd_sel_i;
        end
        if (state_q == DIVWAIT && div_ack_i) begin
            div_res_q <= {div_rem_i, div_quot_i};
        end
    end

    ////////////////////
    // operand magnitudes and 16x16 partial products
    assign sgn   = op_is_signed(op_q);
    assign a_abs = (sgn && rs_q[DATA_W-1]) ? -rs_q : rs_q;
    assign b_abs = (sgn && rt_q[DATA_W-1]) ? -rt_q : rt_q;

    assign pp_ll = a_abs[HALF_W-1:0] * b_abs[HALF_W-1:0];
    assign pp_hl = a_abs[DATA_W-1:HALF_W] * b_abs[HALF_W-1:0];
    assign pp_lh = a_abs[HALF_W-1:0] * b_abs[DATA_W-1:HALF_W];
    assign pp_hh = a_abs[DATA_W-1:HALF_W] * b_abs[DATA_W-1:HALF_W];

    assign mul_lo_o  = {pp_hl, pp_ll};
    assign mul_hi_o  = {pp_hh, pp_lh};
    assign mul_neg_o = sgn && (rs_q[DATA_W-1] ^ rt_q[DATA_W-1]);

    assign div_req_o    = div_req_q;
    assign div_signed_o = sgn;
    assign div_a_o      = rs_q;
    assign div_b_o      = rt_q;
    assign div_res_o    = div_res_q;

    assign op_o      = op_q;
    assign res_src_o = rs_q;
    assign sel_o     = sel_q;
    assign wb_o      = (state_q == EXEC);
    assign cmd_ack_o = (state_q == ACK);

    a_no_div_req_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == IDLE) |-> !div_req_o);

    a_wb_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_o |=> !wb_o);

endmodule

`default_nettype wire

//--- verilog/mdu_divider.sv
////////////////////
// mdu divider
// 32-step restoring divide with four-phase req/ack
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mdu_divider (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire                          div_req_i,
    input  wire                          div_signed_i,
    input  wire [mdu_pkg::DATA_W-1:0]    div_a_i,
    input  wire [mdu_pkg::DATA_W-1:0]    div_b_i,
    output logic                         div_ack_o,
    output logic [mdu_pkg::DATA_W-1:0]   div_quot_o,
    output logic [mdu_pkg::DATA_W-1:0]   div_rem_o
);
    import mdu_pkg::*;

    typedef enum logic [1:0] {D_IDLE, D_RUN, D_FIX, D_ACK} state_e;

    state_e                      state_q;
    logic [$clog2(DATA_W)-1:0]   step_q;
    logic [DATA_W-1:0]           quot_q;
    logic [DATA_W-1:0]           rem_q;
    logic [DATA_W-1:0]           dsor_q;
    logic                        quot_neg_q;
    logic                        rem_neg_q;
    logic                        by_zero_q;
    logic                        a_neg;
    logic                        b_neg;
    logic [DATA_W:0]             shifted;
    logic [DATA_W:0]             trial;

    assign a_neg = div_signed_i && div_a_i[DATA_W-1];
    assign b_neg = div_signed_i && div_b_i[DATA_W-1];

    // sign bit of trial flags a failed subtract in one restoring step
    assign shifted = {rem_q, quot_q[DATA_W-1]};
    assign trial   = shifted - {1'b0, dsor_q};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= D_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                D_IDLE: begin
                    if (div_req_i) begin
                        state_q <= D_RUN;
                        step_q  <= '0;
                    end
                end
                D_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == DATA_W - 1) begin
                        state_q <= D_FIX;
                    end
                end
                D_FIX: state_q <= D_ACK;
                D_ACK: begin
                    if (!div_req_i) begin
                        state_q <= D_IDLE;
                    end
                end
                default: state_q <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            D_IDLE: begin
                quot_q     <= a_neg ? -div_a_i : div_a_i;
                dsor_q     <= b_neg ? -div_b_i : div_b_i;
                rem_q      <= '0;
                quot_neg_q <= a_neg ^ b_neg;
                rem_neg_q  <= a_neg;
                by_zero_q  <= (div_b_i == '0);
            end
            D_RUN: begin
                rem_q  <= trial[DATA_W] ? shifted[DATA_W-1:0] : trial[DATA_W-1:0];
                quot_q <= {quot_q[DATA_W-2:0], ~trial[DATA_W]};
            end
            // the remainder already holds the dividend magnitude on a zero divisor
            D_FIX: begin
                quot_q <= by_zero_q ? DIV_ZERO_QUOT : (quot_neg_q ? -quot_q : quot_q);
                rem_q  <= rem_neg_q ? -rem_q : rem_q;
            end
            default: ;
        endcase
    end

    assign div_ack_o  = (state_q == D_ACK);
    assign div_quot_o = quot_q;
    assign div_rem_o  = rem_q;

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(div_ack_o) |-> div_req_i);

endmodule

`default_nettype wire

//--- verilog/mdu_mem_stage.sv
////////////////////
// mdu memory stage
// product assembly, accumulate and result selection
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mdu_mem_stage #(
    parameter int CP0_REGS = 8
) (
    input  wire mdu_pkg::mdu_op_e           op_i,
    input  wire [mdu_pkg::DATA_W-1:0]       res_src_i,
    input  wire [$clog2(CP0_REGS):0]        sel_i,
    input  wire [mdu_pkg::DWORD_W-1:0]      mul_lo_i,
    input  wire [mdu_pkg::DWORD_W-1:0]      mul_hi_i,
    input  wire                             mul_neg_i,
    input  wire [mdu_pkg::DWORD_W-1:0]      div_res_i,
    input  wire                             wb_i,
    input  wire [mdu_pkg::DWORD_W-1:0]      hilo_rdata_i,
    input  wire [mdu_pkg::DATA_W-1:0]       cp0_rdata_i,
    output logic [mdu_pkg::DATA_W-1:0]      res_o,
    output logic                            hilo_wen_o,
    output logic [mdu_pkg::DWORD_W-1:0]     hilo_wdata_o,
    output logic                            cp0_wen_o,
    output logic [$clog2(CP0_REGS):0]       cp0_addr_o,
    output logic [mdu_pkg::DATA_W-1:0]      cp0_wdata_o
);
    import mdu_pkg::*;

    localparam int PART_W = DATA_W + HALF_W;

    logic [PART_W-1:0]  sum_lo;
    logic [PART_W-1:0]  sum_hi;
    logic [DWORD_W-1:0] prod_u;
    logic [DWORD_W-1:0] prod_s;
    logic               hilo_wr;
    logic               cp0_wr;

    ////////////////////
    // fold the partial products
    assign sum_lo = {{HALF_W{1'b0}}, mul_lo_i[DATA_W-1:0]} +
                    {mul_lo_i[DWORD_W-1:DATA_W], {HALF_W{1'b0}}};
    assign sum_hi = {{HALF_W{1'b0}}, mul_hi_i[DATA_W-1:0]} +
                    {mul_hi_i[DWORD_W-1:DATA_W], {HALF_W{1'b0}}};
    assign prod_u = {{HALF_W{1'b0}}, sum_lo} + {sum_hi, {HALF_W{1'b0}}};
    assign prod_s = mul_neg_i ? (~prod_u + 64'd1) : prod_u;

    ////////////////////
    // per-opcode selection
    always_comb begin
        res_o        = res_src_i;
        hilo_wr      = 1'b0;
        hilo_wdata_o = hilo_rdata_i;
        cp0_wr       = 1'b0;
        cp0_wdata_o  = res_src_i;
        case (op_i)
            OP_MFHI: res_o = hilo_rdata_i[DWORD_W-1:DATA_W];
            OP_MFLO: res_o = hilo_rdata_i[DATA_W-1:0];
            OP_MUL:  res_o = prod_s[DATA_W-1:0];
            OP_MTHI: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = {res_src_i, hilo_rdata_i[DATA_W-1:0]};
            end
            OP_MTLO: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = {hilo_rdata_i[DWORD_W-1:DATA_W], res_src_i};
            end
            OP_MULT: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = prod_s;
            end
            OP_MULTU: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = prod_u;
            end
            OP_MADD: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = hilo_rdata_i + prod_s;
            end
            OP_MADDU: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = hilo_rdata_i + prod_u;
            end
            OP_MSUB: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = hilo_rdata_i - prod_s;
            end
            OP_MSUBU: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = hilo_rdata_i - prod_u;
            end
            // remainder to hi, quotient to lo
            OP_DIV, OP_DIVU: begin
                hilo_wr      = 1'b1;
                hilo_wdata_o = div_res_i;
            end
            OP_MFC0: res_o = cp0_rdata_i;
            OP_MTC0: cp0_wr = 1'b1;
            default: ;
        endcase
    end

    assign hilo_wen_o = wb_i && hilo_wr;
    assign cp0_wen_o  = wb_i && cp0_wr;
    assign cp0_addr_o = sel_i;

    a_wen_excl: assert final (!(hilo_wen_o && cp0_wen_o));

endmodule

`default_nettype wire

//--- verilog/mdu_arch_regs.sv
////////////////////
// mdu architectural registers
// hi/lo pair and cp0 scratch bank
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mdu_arch_regs #(
    parameter int CP0_REGS = 8
) (
    input  wire                           clk_i,
    input  wire                           rst_n_i,
    input  wire                           hilo_wen_i,
    input  wire [mdu_pkg::DWORD_W-1:0]    hilo_wdata_i,
    output logic [mdu_pkg::DWORD_W-1:0]   hilo_rdata_o,
    input  wire                           cp0_wen_i,
    input  wire [$clog2(CP0_REGS):0]      cp0_addr_i,
    input  wire [mdu_pkg::DATA_W-1:0]     cp0_wdata_i,
    output logic [mdu_pkg::DATA_W-1:0]    cp0_rdata_o
);
    import mdu_pkg::*;

    localparam int IDX_W = $clog2(CP0_REGS);

    logic [DWORD_W-1:0] hilo_q;
    logic [DATA_W-1:0]  cp0_q [CP0_REGS];
    logic               in_range;
    logic [IDX_W-1:0]   idx;

    // selects past the bank read zero and drop writes
    assign in_range = (cp0_addr_i < CP0_REGS);
    assign idx      = cp0_addr_i[IDX_W-1:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hilo_q <= '0;
            for (int i = 0; i < CP0_REGS; i++) begin
                cp0_q[i] <= '0;
            end
        end else begin
            if (hilo_wen_i) begin
                hilo_q <= hilo_wdata_i;
            end
            if (cp0_wen_i && in_range) begin
                cp0_q[idx] <= cp0_wdata_i;
            end
        end
    end

    assign hilo_rdata_o = hilo_q;
    assign cp0_rdata_o  = in_range ? cp0_q[idx] : '0;

endmodule

`default_nettype wire

//--- verilog/mdu_top.sv
////////////////////
// mdu top level
// execute and memory stages, divider and register bank
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mdu_top #(
    parameter int CP0_REGS = 8
) (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire                          cmd_req_i,
    input  wire mdu_pkg::mdu_op_e        cmd_op_i,
    input  wire [mdu_pkg::DATA_W-1:0]    cmd_rs_i,
    input  wire [mdu_pkg::DATA_W-1:0]    cmd_rt_i,
    input  wire [$clog2(CP0_REGS):0]     cmd_sel_i,
    output logic                         cmd_ack_o,
    output logic [mdu_pkg::DATA_W-1:0]   cmd_res_o
);
    import mdu_pkg::*;

    localparam int SEL_W = $clog2(CP0_REGS) + 1;

    // execute stage to divider
    logic               div_req;
    logic               div_signed;
    logic [DATA_W-1:0]  div_a;
    logic [DATA_W-1:0]  div_b;
    logic               div_ack;
    logic [DATA_W-1:0]  div_quot;
    logic [DATA_W-1:0]  div_rem;

    // execute stage to memory stage
    mdu_op_e            op;
    logic [DATA_W-1:0]  res_src;
    logic [SEL_W-1:0]   sel;
    logic [DWORD_W-1:0] mul_lo;
    logic [DWORD_W-1:0] mul_hi;
    logic               mul_neg;
    logic [DWORD_W-1:0] div_res;
    logic               wb;

    // memory stage and register bank
    logic [DATA_W-1:0]  mem_res;
    logic               hilo_wen;
    logic [DWORD_W-1:0] hilo_wdata;
    logic [DWORD_W-1:0] hilo_rdata;
    logic               cp0_wen;
    logic [SEL_W-1:0]   cp0_addr;
    logic [DATA_W-1:0]  cp0_wdata;
    logic [DATA_W-1:0]  cp0_rdata;

    mdu_ex_stage #(
        .CP0_REGS (CP0_REGS)
    ) u_ex (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .cmd_req_i    (cmd_req_i),
        .cmd_ack_o    (cmd_ack_o),
        .cmd_op_i     (cmd_op_i),
        .cmd_rs_i     (cmd_rs_i),
        .cmd_rt_i     (cmd_rt_i),
        .cmd_sel_i    (cmd_sel_i),
        .div_req_o    (div_req),
        .div_signed_o (div_signed),
        .div_a_o      (div_a),
        .div_b_o      (div_b),
        .div_ack_i    (div_ack),
        .div_quot_i   (div_quot),
        .div_rem_i    (div_rem),
        .op_o         (op),
        .res_src_o    (res_src),
        .sel_o        (sel),
        .mul_lo_o     (mul_lo),
        .mul_hi_o     (mul_hi),
        .mul_neg_o    (mul_neg),
        .div_res_o    (div_res),
        .wb_o         (wb)
    );

    mdu_divider u_div (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .div_req_i    (div_req),
        .div_signed_i (div_signed),
        .div_a_i      (div_a),
        .div_b_i      (div_b),
        .div_ack_o    (div_ack),
        .div_quot_o   (div_quot),
        .div_rem_o    (div_rem)
    );

    mdu_mem_stage #(
        .CP0_REGS (CP0_REGS)
    ) u_mem (
        .op_i         (op),
        .res_src_i    (res_src),
        .sel_i        (sel),
        .mul_lo_i     (mul_lo),
        .mul_hi_i     (mul_hi),
        .mul_neg_i    (mul_neg),
        .div_res_i    (div_res),
        .wb_i         (wb),
        .hilo_rdata_i (hilo_rdata),
        .cp0_rdata_i  (cp0_rdata),
        .res_o        (mem_res),
        .hilo_wen_o   (hilo_wen),
        .hilo_wdata_o (hilo_wdata),
        .cp0_wen_o    (cp0_wen),
        .cp0_addr_o   (cp0_addr),
        .cp0_wdata_o  (cp0_wdata)
    );

    mdu_arch_regs #(
        .CP0_REGS (CP0_REGS)
    ) u_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .hilo_wen_i   (hilo_wen),
        .hilo_wdata_i (hilo_wdata),
        .hilo_rdata_o (hilo_rdata),
        .cp0_wen_i    (cp0_wen),
        .cp0_addr_i   (cp0_addr),
        .cp0_wdata_i  (cp0_wdata),
        .cp0_rdata_o  (cp0_rdata)
    );

    // result register loads once per command on the commit strobe
    always_ff @(posedge clk_i) begin
        if (wb) begin
            cmd_res_o <= mem_res;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_mdu_tests.svh
////////////////////
// mdu directed tests
// each task drives commands and checks them against the model
////////////////////
`ifndef TB_MDU_TESTS_SVH
`define TB_MDU_TESTS_SVH

// read hi/lo back through MFHI and MFLO
task automatic compare_hilo(input string tag);
    logic [31:0] hi;
    logic [31:0] lo;
    int          lat;
    issue_cmd(OP_MFHI, '0, '0, '0, 0, hi, lat);
    issue_cmd(OP_MFLO, '0, '0, '0, 0, lo, lat);
    check_value({"cmd_res_o (MFHI after ", tag, ")"}, hi, hilo_m[63:32]);
    check_value({"cmd_res_o (MFLO after ", tag, ")"}, lo, hilo_m[31:0]);
endtask

// hi/lo reads zero after reset and acks two edges after req is driven
task automatic reset_state_reads();
    mdu_op_e     ops [2] = '{OP_MFHI, OP_MFLO};
    mdu_op_e     op;
    logic [31:0] res;
    int          lat;
    for (int i = 0; i < 2; i++) begin
        op = ops[i];
        issue_cmd(op, '0, '0, '0, 0, res, lat);
        check_value({"cmd_res_o (", op.name(), " after reset)"}, res, '0);
        assert (lat == 2)
        else report_error($sformatf("mismatch at %0t: %s ack latency got %0d expected 2",
                                    $time, op.name(), lat));
    end
endtask

task automatic move_hilo_halves();
    logic [31:0] v;
    logic [31:0] res;
    int          lat;
    draw_word(v);
    issue_cmd(OP_MTHI, v, '0, '0, 0, res, lat);
    hilo_m[63:32] = v;
    compare_hilo("MTHI");
    draw_word(v);
    issue_cmd(OP_MTLO, v, '0, '0, 0, res, lat);
    hilo_m[31:0] = v;
    compare_hilo("MTLO");
    // second MTHI must keep the lo word written above
    draw_word(v);
    issue_cmd(OP_MTHI, v, '0, '0, 0, res, lat);
    hilo_m[63:32] = v;
    compare_hilo("second MTHI");
endtask

// corner pairs first and random operands after them
task automatic multiply_products();
    logic [31:0] corners [4] = '{32'h0, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [63:0] p;
    int          lat;
    for (int i = 0; i < 24; i++) begin
        if (i < 16) begin
            a = corners[i / 4];
            b = corners[i % 4];
        end else begin
            draw_word(a);
            draw_word(b);
        end
        issue_cmd(OP_MULT, a, b, '0, 0, res, lat);
        hilo_m = signed_product(a, b);
        compare_hilo("MULT");
        issue_cmd(OP_MULTU, a, b, '0, 0, res, lat);
        hilo_m = unsigned_product(a, b);
        compare_hilo("MULTU");
        // MUL leaves hi/lo alone
        issue_cmd(OP_MUL, a, b, '0, 0, res, lat);
        p = signed_product(a, b);
        check_value("cmd_res_o (MUL)", res, p[31:0]);
    end
endtask

task automatic accumulate_chain();
    mdu_op_e     ops [4] = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    mdu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    int          lat;
    for (int i = 0; i < 12; i++) begin
        op = ops[i % 4];
        draw_word(a);
        draw_word(b);
        issue_cmd(op, a, b, '0, 0, res, lat);
        case (op)
            OP_MADD:  hilo_m = hilo_m + signed_product(a, b);
            OP_MADDU: hilo_m = hilo_m + unsigned_product(a, b);
            OP_MSUB:  hilo_m = hilo_m - signed_product(a, b);
            default:  hilo_m = hilo_m - unsigned_product(a, b);
        endcase
        compare_hilo(op.name());
    end
endtask

// mixed signs, the overflow case and zero divisors before random operands
task automatic divide_results();
    logic [31:0] a_list [7] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9,
                                32'h8000_0000, 32'h1234_5678, 32'h0};
    logic [31:0] b_list [7] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe,
                                32'hffff_ffff, 32'h0, 32'h0};
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    int          lat;
    for (int i = 0; i < 13; i++) begin
        if (i < 7) begin
            a = a_list[i];
            b = b_list[i];
        end else begin
            draw_word(a);
            draw_word(b);
            b = b >> (i * 3);
        end
        issue_cmd(OP_DIV, a, b, '0, 0, res, lat);
        hilo_m = div_model(a, b, 1'b1);
        compare_hilo("DIV");
        issue_cmd(OP_DIVU, a, b, '0, 0, res, lat);
        hilo_m = div_model(a, b, 1'b0);
        compare_hilo("DIVU");
    end
endtask

// writes to selects past the bank must not alias into it
task automatic cp0_readback();
    logic [31:0] v;
    logic [31:0] res;
    int          lat;
    for (int s = 0; s < 2 * CP0_REGS; s++) begin
        draw_word(v);
        issue_cmd(OP_MTC0, v, '0, s[SEL_W-1:0], 0, res, lat);
        if (s < CP0_REGS) begin
            cp0_m[s] = v;
        end
    end
    for (int s = 0; s < 2 * CP0_REGS; s++) begin
        issue_cmd(OP_MFC0, '0, '0, s[SEL_W-1:0], 0, res, lat);
        v = (s < CP0_REGS) ? cp0_m[s] : '0;
        check_value($sformatf("cmd_res_o (MFC0 sel %0d)", s), res, v);
    end
endtask

// accumulate must apply once while req stays high
task automatic held_request();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    int          lat;
    draw_word(a);
    draw_word(b);
    issue_cmd(OP_MADD, a, b, '0, 6, res, lat);
    hilo_m = hilo_m + signed_product(a, b);
    compare_hilo("MADD with req held");
endtask

`endif

//--- bench/tb_mdu.sv
////////////////////
// mdu testbench
// directed commands checked against a model of hi/lo and cp0
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mdu;
    import mdu_pkg::*;

    localparam int CP0_REGS     = 8;
    localparam int SEL_W        = $clog2(CP0_REGS) + 1;
    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_SKEW   = 2;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_LIMIT    = 100;
    // about 330 commands in all
    // a divide takes under 40 cycles
    localparam int MAX_CMDS     = 400;
    localparam int CMD_CYCLES   = 60;

    logic               clk;
    logic               rst_n;
    logic               cmd_req;
    mdu_op_e            cmd_op;
    logic [DATA_W-1:0]  cmd_rs;
    logic [DATA_W-1:0]  cmd_rt;
    logic [SEL_W-1:0]   cmd_sel;
    logic               cmd_ack;
    logic [DATA_W-1:0]  cmd_res;

    // reference state
    logic [DWORD_W-1:0] hilo_m;
    logic [DATA_W-1:0]  cp0_m [CP0_REGS];
    logic [31:0]        rng;

    mdu_top #(
        .CP0_REGS (CP0_REGS)
    ) i_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .cmd_req_i (cmd_req),
        .cmd_op_i  (cmd_op),
        .cmd_rs_i  (cmd_rs),
        .cmd_rt_i  (cmd_rt),
        .cmd_sel_i (cmd_sel),
        .cmd_ack_o (cmd_ack),
        .cmd_res_o (cmd_res)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("mismatch at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_word(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    function automatic logic [63:0] signed_product(input logic [31:0] a, input logic [31:0] b);
        longint pa;
        longint pb;
        pa = longint'($signed(a));
        pb = longint'($signed(b));
        return pa * pb;
    endfunction

    function automatic logic [63:0] unsigned_product(input logic [31:0] a,
                                                     input logic [31:0] b);
        return {32'b0, a} * {32'b0, b};
    endfunction

    // truncating division giving {remainder, quotient}
    function automatic logic [63:0] div_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn);
        longint na;
        longint nb;
        longint q;
        longint r;
        if (b == '0) begin
            return {a, DIV_ZERO_QUOT};
        end
        na = sgn ? longint'($signed(a)) : longint'({32'b0, a});
        nb = sgn ? longint'($signed(b)) : longint'({32'b0, b});
        q  = na / nb;
        r  = na % nb;
        return {r[31:0], q[31:0]};
    endfunction

    // four-phase command with an optional hold of req after ack
    task automatic issue_cmd(input mdu_op_e op, input logic [31:0] rs, input logic [31:0] rt,
                             input logic [SEL_W-1:0] sel, input int hold,
                             output logic [31:0] res, output int lat);
        int fall_n;
        cmd_op  = op;
        cmd_rs  = rs;
        cmd_rt  = rt;
        cmd_sel = sel;
        cmd_req = 1'b1;
        lat     = 0;
        while (!cmd_ack && lat < ACK_LIMIT) begin
            @(posedge clk);
            #(DRIVE_SKEW);
            lat++;
        end
        assert (cmd_ack)
        else report_error($sformatf("no ack for %s within %0d cycles", op.name(), ACK_LIMIT));
        res = cmd_res;
        repeat (hold) begin
            @(posedge clk);
            #(DRIVE_SKEW);
            assert (cmd_ack)
            else report_error($sformatf("ack dropped at %0t while req was held", $time));
            check_value("cmd_res_o (req held)", cmd_res, res);
        end
        cmd_req = 1'b0;
        fall_n  = 0;
        while (cmd_ack && fall_n < ACK_LIMIT) begin
            @(posedge clk);
            #(DRIVE_SKEW);
            fall_n++;
        end
        assert (!cmd_ack)
        else report_error($sformatf("ack for %s never fell after req was released", op.name()));
    endtask

    `include "tb_mdu_tests.svh"

    initial begin
        rst_n   = 1'b0;
        cmd_req = 1'b0;
        cmd_op  = OP_NOP;
        cmd_rs  = '0;
        cmd_rt  = '0;
        cmd_sel = '0;
        hilo_m  = '0;
        rng     = 32'he4b4;
        for (int i = 0; i < CP0_REGS; i++) begin
            cp0_m[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_SKEW);
        rst_n = 1'b1;
        @(posedge clk);
        #(DRIVE_SKEW);

        reset_state_reads();
        move_hilo_halves();
        multiply_products();
        accumulate_chain();
        divide_results();
        cp0_readback();
        held_request();

        $display("TEST PASSED");
        $finish;
    end

    ////////////////////
    // watchdog
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + MAX_CMDS * CMD_CYCLES + 200));
        report_error($sformatf("watchdog expired at %0t before the tests finished", $time));
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+bench
verilog/mdu_pkg.sv
verilog/mdu_ex_stage.sv
verilog/mdu_divider.sv
verilog/mdu_mem_stage.sv
verilog/mdu_arch_regs.sv
verilog/mdu_top.sv
bench/tb_mdu.sv

//--- run_sim.sh
#!/bin/sh
# build the mdu testbench with verilator and run it
# exits nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        --top-module tb_mdu -Mdir obj_dir -f verilog.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_mdu; then
    echo "simulation ended with an error"
    exit 1
fi

exit 0
